/* design/dbg_cpu_pkg.sv */
`default_nettype none

package dbg_cpu_pkg;

  //////////////////////////////
  // Field widths

  localparam int DATAREG_LEN = 64;  // JTAG data register
  localparam int WORD_BITS   = 32;  // Only 32-bit bus accesses
  localparam int ADDR_LEN    = 32;
  localparam int COUNT_LEN   = 16;  // Words per burst
  localparam int BITCNT_LEN  = 6;   // Must reach 32 for the write CRC
  localparam int OPCODE_LEN  = 4;

  // Bit counter compare points
  localparam logic [BITCNT_LEN-1:0] BIT_LAST     = BITCNT_LEN'(WORD_BITS - 1);
  localparam logic [BITCNT_LEN-1:0] BIT_CRC_DONE = BITCNT_LEN'(WORD_BITS);

  // Opcode bit 2 marks a read
  localparam logic [OPCODE_LEN-1:0] CMD_BWRITE32 = 4'h3;
  localparam logic [OPCODE_LEN-1:0] CMD_BREAD32  = 4'h7;
  localparam logic [OPCODE_LEN-1:0] CMD_IREG_WR  = 4'h9;
  localparam logic [OPCODE_LEN-1:0] CMD_IREG_SEL = 4'hd;

  localparam logic INTREG_STATUS = 1'b0;  // Stall register, the only one

  localparam logic [WORD_BITS-1:0] CRC_POLY = 32'hedb88320;  // Reflected CRC-32
  localparam logic [WORD_BITS-1:0] CRC_INIT = 32'hffffffff;

  //////////////////////////////
  // Burst FSM

  typedef enum logic [3:0] {
    ST_IDLE    = 4'b1011,
    ST_RBEGIN  = 4'b1010,
    ST_RREADY  = 4'b1001,
    ST_RSTATUS = 4'b1000,
    ST_RBURST  = 4'b0111,
    ST_WREADY  = 4'b0110,
    ST_WWAIT   = 4'b0101,
    ST_WBURST  = 4'b0100,
    ST_RCRC    = 4'b0010,
    ST_WCRC    = 4'b0001,
    ST_WMATCH  = 4'b0000
  } state_e;

  // TDO source
  localparam logic [1:0] TDO_READY = 2'b11;
  localparam logic [1:0] TDO_DATA  = 2'b10;
  localparam logic [1:0] TDO_MATCH = 2'b01;
  localparam logic [1:0] TDO_CRC   = 2'b00;

  // Data register seen as burst or internal register command
  typedef union packed {
    struct packed {
      logic                  top_cmd;  // Set for the top level, start bit in a write
      logic [OPCODE_LEN-1:0] opcode;
      logic [3:0]            spare;
      logic [ADDR_LEN-1:0]   addr;
      logic [COUNT_LEN-1:0]  count;
      logic [DATAREG_LEN-ADDR_LEN-COUNT_LEN-OPCODE_LEN-6:0] unused;
    } burst;
    struct packed {
      logic                  top_cmd;
      logic [OPCODE_LEN-1:0] opcode;
      logic                  reg_sel;
      logic                  stall;    // New stall value
      logic [DATAREG_LEN-OPCODE_LEN-4:0] unused;
    } ireg;
  } dbg_cmd_u;

endpackage

`default_nettype wire

/* design/dbg_cpu_crc32.sv */
`timescale 1ns/1ns
`default_nettype none

module dbg_cpu_crc32 (
  input  logic                                tck_i,
  input  logic                                tlr_i,
  input  logic                                data_i,    // Serial bit into the CRC
  input  logic                                enable_i,  // One CRC step
  input  logic                                shift_i,   // Shift out without update
  input  logic                                clr_i,     // Back to the seed
  output logic [dbg_cpu_pkg::WORD_BITS-1:0]   crc_o,
  output logic                                serial_o
);

  logic [dbg_cpu_pkg::WORD_BITS-1:0] crc_q;
  logic                              feedback;

  assign feedback = data_i ^ crc_q[0];  // LSB first, reflected form

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      crc_q <= dbg_cpu_pkg::CRC_INIT;
    end else if (clr_i) begin
      crc_q <= dbg_cpu_pkg::CRC_INIT;
    end else if (enable_i) begin
      crc_q <= {1'b0, crc_q[dbg_cpu_pkg::WORD_BITS-1:1]}
               ^ (feedback ? dbg_cpu_pkg::CRC_POLY : '0);
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[dbg_cpu_pkg::WORD_BITS-1:1]};  // Own output shift register
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];

endmodule

`default_nettype wire

/* design/dbg_cpu_biu.sv */
`timescale 1ns/1ns
`default_nettype none

module dbg_cpu_biu (
  input  logic                              tck_i,
  input  logic                              tlr_i,
  // Request side
  input  logic                              strobe_i,  // Latch request and start
  input  logic                              rd_wrn_i,  // 1 for read
  input  logic [dbg_cpu_pkg::ADDR_LEN-1:0]  addr_i,
  input  logic [dbg_cpu_pkg::WORD_BITS-1:0] data_i,
  output logic [dbg_cpu_pkg::WORD_BITS-1:0] data_o,    // Read data
  output logic                              rdy_o,
  // CPU bus
  output logic [dbg_cpu_pkg::ADDR_LEN-1:0]  cpu_addr_o,
  input  logic [dbg_cpu_pkg::WORD_BITS-1:0] cpu_data_i,
  output logic [dbg_cpu_pkg::WORD_BITS-1:0] cpu_data_o,
  output logic                              cpu_stb_o,
  output logic                              cpu_we_o,
  input  logic                              cpu_ack_i
);

  logic done;

  assign done = cpu_stb_o & cpu_ack_i;  // Bus cycle ends on this edge

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      rdy_o      <= 1'b1;
      cpu_stb_o  <= 1'b0;
      cpu_we_o   <= 1'b0;
      cpu_addr_o <= '0;
      cpu_data_o <= '0;
      data_o     <= '0;
    end else if (strobe_i) begin
      rdy_o      <= 1'b0;
      cpu_stb_o  <= 1'b1;      // Bus cycle from the next cycle on
      cpu_we_o   <= ~rd_wrn_i;
      cpu_addr_o <= addr_i;
      cpu_data_o <= data_i;
    end else if (done) begin
      rdy_o     <= 1'b1;
      cpu_stb_o <= 1'b0;
      cpu_we_o  <= 1'b0;
      if (!cpu_we_o) data_o <= cpu_data_i;  // Capture with ack
    end
  end

  // Bus cycle is held until the CPU answers
  assert property (@(posedge tck_i) disable iff (tlr_i)
    cpu_stb_o && !cpu_ack_i |=> cpu_stb_o);

endmodule

`default_nettype wire

/* design/dbg_cpu_status_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module dbg_cpu_status_reg (
  input  logic tck_i,
  input  logic tlr_i,
  input  logic we_i,     // Debugger write
  input  logic data_i,   // Stall value to write
  input  logic bp_i,     // Breakpoint from the core
  output logic stall_o
);

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      stall_o <= 1'b0;
    end else if (bp_i) begin
      stall_o <= 1'b1;    // Breakpoint wins over a write
    end else if (we_i) begin
      stall_o <= data_i;
    end
  end

endmodule

`default_nettype wire

/* design/dbg_cpu_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dbg_cpu_ctrl (
  input  logic                  tck_i,
  input  logic                  tlr_i,
  // TAP strobes
  input  logic                  capture_dr_i,
  input  logic                  shift_dr_i,
  input  logic                  update_dr_i,
  input  logic                  module_select_i,
  input  dbg_cpu_pkg::dbg_cmd_u cmd_i,
  // Status from datapath and BIU
  input  logic                  word_count_zero_i,
  input  logic                  word_count_one_i,
  input  logic                  bit_count_max_i,
  input  logic                  bit_count_32_i,
  input  logic                  biu_ready_i,
  // Datapath controls
  output logic                  addr_sel_o,          // 1 increments
  output logic                  addr_ct_en_o,
  output logic                  op_reg_en_o,
  output logic                  bit_ct_en_o,
  output logic                  bit_ct_rst_o,
  output logic                  word_ct_sel_o,       // 1 decrements
  output logic                  word_ct_en_o,
  output logic                  out_reg_ld_en_o,
  output logic                  out_reg_shift_en_o,
  output logic                  out_reg_data_sel_o,  // 1 for status register
  output logic [1:0]            tdo_sel_o,
  output logic                  biu_strobe_o,
  // CRC controls
  output logic                  crc_clr_o,
  output logic                  crc_en_o,
  output logic                  crc_in_sel_o,        // 1 for tdi
  output logic                  crc_shift_en_o,
  output logic                  status_wr_o,
  output logic                  top_inhibit_o
);

  dbg_cpu_pkg::state_e state_q;
  dbg_cpu_pkg::state_e state_d;
  logic                module_cmd;
  logic                burst_instr;
  logic                rd_fetch;   // Load next read word

  //////////////////////////////
  // Command decode ahead of the opcode latch

  assign module_cmd  = ~cmd_i.burst.top_cmd;
  assign burst_instr = (cmd_i.burst.opcode == dbg_cpu_pkg::CMD_BWRITE32)
                     | (cmd_i.burst.opcode == dbg_cpu_pkg::CMD_BREAD32);

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) state_q <= dbg_cpu_pkg::ST_IDLE;
    else state_q <= state_d;
  end

  //////////////////////////////
  // Next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      dbg_cpu_pkg::ST_IDLE:
        if (module_select_i && module_cmd && update_dr_i && burst_instr)
          state_d = cmd_i.burst.opcode[2] ? dbg_cpu_pkg::ST_RBEGIN : dbg_cpu_pkg::ST_WREADY;
      dbg_cpu_pkg::ST_RBEGIN:
        state_d = word_count_zero_i ? dbg_cpu_pkg::ST_IDLE : dbg_cpu_pkg::ST_RREADY;
      dbg_cpu_pkg::ST_RREADY:
        if (module_select_i && capture_dr_i) state_d = dbg_cpu_pkg::ST_RSTATUS;
      dbg_cpu_pkg::ST_RSTATUS:
        if (biu_ready_i) state_d = dbg_cpu_pkg::ST_RBURST;
      dbg_cpu_pkg::ST_RBURST:
        if (bit_count_max_i && word_count_zero_i) state_d = dbg_cpu_pkg::ST_RCRC;
      dbg_cpu_pkg::ST_WREADY:
        if (word_count_zero_i) state_d = dbg_cpu_pkg::ST_IDLE;  // Empty burst
        else if (module_select_i && capture_dr_i) state_d = dbg_cpu_pkg::ST_WWAIT;
      dbg_cpu_pkg::ST_WWAIT:
        if (module_select_i && cmd_i.burst.top_cmd) state_d = dbg_cpu_pkg::ST_WBURST;
      dbg_cpu_pkg::ST_WBURST:
        if (bit_count_max_i && word_count_zero_i) state_d = dbg_cpu_pkg::ST_WCRC;
      dbg_cpu_pkg::ST_WCRC:
        if (bit_count_32_i) state_d = dbg_cpu_pkg::ST_WMATCH;
      dbg_cpu_pkg::ST_RCRC, dbg_cpu_pkg::ST_WMATCH: ;  // Held until update
      default: state_d = dbg_cpu_pkg::ST_IDLE;
    endcase
    // Update ends any burst
    if (update_dr_i && state_q != dbg_cpu_pkg::ST_IDLE) state_d = dbg_cpu_pkg::ST_IDLE;
  end

  //////////////////////////////
  // Outputs

  always_comb begin
    addr_sel_o         = 1'b1;
    addr_ct_en_o       = 1'b0;
    op_reg_en_o        = 1'b0;
    bit_ct_en_o        = 1'b0;
    bit_ct_rst_o       = 1'b0;
    word_ct_sel_o      = 1'b1;
    word_ct_en_o       = 1'b0;
    out_reg_ld_en_o    = 1'b0;
    out_reg_shift_en_o = 1'b0;
    out_reg_data_sel_o = 1'b1;
    tdo_sel_o          = dbg_cpu_pkg::TDO_DATA;
    biu_strobe_o       = 1'b0;
    crc_clr_o          = 1'b0;
    crc_en_o           = 1'b0;
    crc_in_sel_o       = 1'b0;
    crc_shift_en_o     = 1'b0;
    status_wr_o        = 1'b0;
    top_inhibit_o      = 1'b0;
    rd_fetch           = 1'b0;
    case (state_q)
      dbg_cpu_pkg::ST_IDLE: begin
        addr_sel_o    = 1'b0;  // Load from the command
        word_ct_sel_o = 1'b0;
        out_reg_shift_en_o = module_select_i & shift_dr_i;    // Status readback
        out_reg_ld_en_o    = module_select_i & capture_dr_i;
        status_wr_o = module_select_i & module_cmd & update_dr_i
                    & (cmd_i.ireg.opcode == dbg_cpu_pkg::CMD_IREG_WR)
                    & (cmd_i.ireg.reg_sel == dbg_cpu_pkg::INTREG_STATUS);
        if (state_d != dbg_cpu_pkg::ST_IDLE) begin
          addr_ct_en_o = 1'b1;
          op_reg_en_o  = 1'b1;
          bit_ct_rst_o = 1'b1;
          word_ct_en_o = 1'b1;
          crc_clr_o    = 1'b1;
        end
      end
      dbg_cpu_pkg::ST_RBEGIN: begin
        if (state_d == dbg_cpu_pkg::ST_RREADY) begin
          biu_strobe_o = 1'b1;  // First read word
          addr_ct_en_o = 1'b1;
        end
      end
      dbg_cpu_pkg::ST_RSTATUS: begin
        tdo_sel_o     = dbg_cpu_pkg::TDO_READY;
        top_inhibit_o = 1'b1;
        rd_fetch      = (state_d == dbg_cpu_pkg::ST_RBURST);
      end
      dbg_cpu_pkg::ST_RBURST: begin
        out_reg_shift_en_o = 1'b1;
        bit_ct_en_o        = 1'b1;
        crc_en_o           = 1'b1;  // CRC over outgoing bits
        top_inhibit_o      = 1'b1;
        rd_fetch           = bit_count_max_i & ~word_count_zero_i;
      end
      dbg_cpu_pkg::ST_RCRC: begin
        tdo_sel_o      = dbg_cpu_pkg::TDO_CRC;
        crc_shift_en_o = 1'b1;
        top_inhibit_o  = 1'b1;
      end
      dbg_cpu_pkg::ST_WWAIT: begin
        top_inhibit_o = 1'b1;
        if (state_d == dbg_cpu_pkg::ST_WBURST) begin
          bit_ct_en_o  = 1'b1;  // tdi already holds the first data bit
          word_ct_en_o = 1'b1;  // Predecrement
          crc_en_o     = 1'b1;
          crc_in_sel_o = 1'b1;
        end
      end
      dbg_cpu_pkg::ST_WBURST: begin
        bit_ct_en_o   = 1'b1;
        crc_en_o      = 1'b1;
        crc_in_sel_o  = 1'b1;
        top_inhibit_o = 1'b1;
        if (bit_count_max_i) begin
          bit_ct_rst_o = 1'b1;
          biu_strobe_o = 1'b1;  // Full word written
          addr_ct_en_o = 1'b1;
          word_ct_en_o = ~word_count_zero_i;
        end
      end
      dbg_cpu_pkg::ST_WCRC: begin
        bit_ct_en_o   = 1'b1;
        top_inhibit_o = 1'b1;
        if (state_d == dbg_cpu_pkg::ST_WMATCH) tdo_sel_o = dbg_cpu_pkg::TDO_MATCH;
      end
      dbg_cpu_pkg::ST_WMATCH: begin
        tdo_sel_o     = dbg_cpu_pkg::TDO_MATCH;
        top_inhibit_o = 1'b1;
      end
      default: ;  // RREADY and WREADY only wait
    endcase
    // Next read word into the shift register
    if (rd_fetch) begin
      out_reg_data_sel_o = 1'b0;
      out_reg_ld_en_o    = 1'b1;
      out_reg_shift_en_o = 1'b0;  // Load replaces the shift
      bit_ct_rst_o       = 1'b1;
      word_ct_en_o       = 1'b1;
      if (!word_count_one_i) begin
        biu_strobe_o = 1'b1;  // Prefetch while this word shifts
        addr_ct_en_o = 1'b1;
      end
    end
  end

  // A new request only after the BIU finished the last one
  assert property (@(posedge tck_i) disable iff (tlr_i) biu_strobe_o |-> biu_ready_i);

  assert property (@(posedge tck_i) disable iff (tlr_i)
    state_q inside {dbg_cpu_pkg::ST_IDLE, dbg_cpu_pkg::ST_RBEGIN, dbg_cpu_pkg::ST_RREADY,
                    dbg_cpu_pkg::ST_RSTATUS, dbg_cpu_pkg::ST_RBURST, dbg_cpu_pkg::ST_RCRC,
                    dbg_cpu_pkg::ST_WREADY, dbg_cpu_pkg::ST_WWAIT, dbg_cpu_pkg::ST_WBURST,
                    dbg_cpu_pkg::ST_WCRC, dbg_cpu_pkg::ST_WMATCH});

endmodule

`default_nettype wire

/* design/dbg_cpu_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module dbg_cpu_datapath (
  input  logic                              tck_i,
  input  logic                              tlr_i,
  input  logic                              tdi_i,
  input  dbg_cpu_pkg::dbg_cmd_u             cmd_i,
  // Controls from the FSM
  input  logic                              addr_sel_i,
  input  logic                              addr_ct_en_i,
  input  logic                              op_reg_en_i,
  input  logic                              bit_ct_en_i,
  input  logic                              bit_ct_rst_i,
  input  logic                              word_ct_sel_i,
  input  logic                              word_ct_en_i,
  input  logic                              out_reg_ld_en_i,
  input  logic                              out_reg_shift_en_i,
  input  logic                              out_reg_data_sel_i,
  input  logic [1:0]                        tdo_sel_i,
  input  logic                              crc_in_sel_i,
  // Data sources
  input  logic [dbg_cpu_pkg::WORD_BITS-1:0] biu_data_i,
  input  logic                              status_i,
  input  logic                              biu_ready_i,
  input  logic [dbg_cpu_pkg::WORD_BITS-1:0] crc_data_i,
  input  logic                              crc_serial_i,
  output logic [dbg_cpu_pkg::ADDR_LEN-1:0]  addr_o,
  output logic [dbg_cpu_pkg::WORD_BITS-1:0] wdata_o,
  output logic                              rd_op_o,
  output logic                              tdo_o,
  output logic                              crc_bit_o,
  output logic                              crc_match_o,
  output logic                              word_count_zero_o,
  output logic                              word_count_one_o,
  output logic                              bit_count_max_o,
  output logic                              bit_count_32_o
);

  logic [dbg_cpu_pkg::DATAREG_LEN-1:0] dr;
  logic [dbg_cpu_pkg::COUNT_LEN-1:0]   word_count_q;
  logic [dbg_cpu_pkg::BITCNT_LEN-1:0]  bit_count_q;
  logic [dbg_cpu_pkg::OPCODE_LEN-1:0]  opcode_q;
  logic [dbg_cpu_pkg::WORD_BITS-1:0]   out_reg_q;   // Shifts right to TDO

  assign dr = cmd_i;  // Raw view of the TAP register

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      addr_o       <= '0;
      word_count_q <= '0;
      bit_count_q  <= '0;
      opcode_q     <= '0;
      out_reg_q    <= '0;
    end else begin
      if (addr_ct_en_i) addr_o <= addr_sel_i ? addr_o + 1 : cmd_i.burst.addr;  // Word addressed
      if (word_ct_en_i) word_count_q <= word_ct_sel_i ? word_count_q - 1 : cmd_i.burst.count;
      if (bit_ct_rst_i) bit_count_q <= '0;
      else if (bit_ct_en_i) bit_count_q <= bit_count_q + 1;
      if (op_reg_en_i) opcode_q <= cmd_i.burst.opcode;
      if (out_reg_ld_en_i)
        out_reg_q <= out_reg_data_sel_i ? {{(dbg_cpu_pkg::WORD_BITS-1){1'b0}}, status_i}
                                        : biu_data_i;
      else if (out_reg_shift_en_i)
        out_reg_q <= {1'b0, out_reg_q[dbg_cpu_pkg::WORD_BITS-1:1]};
    end
  end

  assign rd_op_o           = opcode_q[2];
  assign word_count_zero_o = (word_count_q == '0);
  assign word_count_one_o  = (word_count_q == 1);
  assign bit_count_max_o   = (bit_count_q == dbg_cpu_pkg::BIT_LAST);
  assign bit_count_32_o    = (bit_count_q == dbg_cpu_pkg::BIT_CRC_DONE);

  // Last bit still on tdi, earlier 31 in the top of the register
  assign wdata_o   = {tdi_i, dr[dbg_cpu_pkg::DATAREG_LEN-1 -: dbg_cpu_pkg::WORD_BITS-1]};
  assign crc_bit_o = crc_in_sel_i ? tdi_i : out_reg_q[0];
  assign crc_match_o = (dr[dbg_cpu_pkg::DATAREG_LEN-1 -: dbg_cpu_pkg::WORD_BITS] == crc_data_i);

  always_comb begin
    case (tdo_sel_i)
      dbg_cpu_pkg::TDO_READY: tdo_o = biu_ready_i;
      dbg_cpu_pkg::TDO_DATA:  tdo_o = out_reg_q[0];
      dbg_cpu_pkg::TDO_MATCH: tdo_o = crc_match_o;
      default:                tdo_o = crc_serial_i;
    endcase
  end

  // Capture and shift never overlap
  assert property (@(posedge tck_i) disable iff (tlr_i)
    !(out_reg_ld_en_i && out_reg_shift_en_i));

endmodule

`default_nettype wire

/* design/dbg_cpu_module.sv */
`timescale 1ns/1ns
`default_nettype none

module dbg_cpu_module (
  input  logic                                tck_i,
  input  logic                                tlr_i,
  // TAP side
  input  logic                                capture_dr_i,
  input  logic                                shift_dr_i,
  input  logic                                update_dr_i,
  input  logic                                tdi_i,
  input  logic [dbg_cpu_pkg::DATAREG_LEN-1:0] data_register_i,
  input  logic                                module_select_i,
  output logic                                module_tdo_o,
  output logic                                top_inhibit_o,
  // CPU bus
  output logic [dbg_cpu_pkg::ADDR_LEN-1:0]    cpu_addr_o,
  output logic [dbg_cpu_pkg::WORD_BITS-1:0]   cpu_data_o,
  input  logic [dbg_cpu_pkg::WORD_BITS-1:0]   cpu_data_i,
  output logic                                cpu_stb_o,
  output logic                                cpu_we_o,
  input  logic                                cpu_ack_i,
  input  logic                                cpu_bp_i,
  output logic                                cpu_stall_o
);

  wire dbg_cpu_pkg::dbg_cmd_u cmd = data_register_i;

  logic                              addr_sel, addr_ct_en, op_reg_en, bit_ct_en, bit_ct_rst;
  logic                              word_ct_sel, word_ct_en;
  logic                              out_reg_ld_en, out_reg_shift_en, out_reg_data_sel;
  logic [1:0]                        tdo_sel;
  logic                              biu_strobe, biu_ready, rd_op, status_wr;
  logic                              crc_clr, crc_en, crc_in_sel, crc_shift_en, crc_bit, crc_serial;
  logic                              word_count_zero, word_count_one, bit_count_max, bit_count_32;
  logic [dbg_cpu_pkg::ADDR_LEN-1:0]  addr;
  logic [dbg_cpu_pkg::WORD_BITS-1:0] wdata, rdata, crc_data;

  dbg_cpu_ctrl u_ctrl (
    .tck_i(tck_i), .tlr_i(tlr_i),
    .capture_dr_i(capture_dr_i), .shift_dr_i(shift_dr_i), .update_dr_i(update_dr_i),
    .module_select_i(module_select_i), .cmd_i(cmd),
    .word_count_zero_i(word_count_zero), .word_count_one_i(word_count_one),
    .bit_count_max_i(bit_count_max), .bit_count_32_i(bit_count_32), .biu_ready_i(biu_ready),
    .addr_sel_o(addr_sel), .addr_ct_en_o(addr_ct_en), .op_reg_en_o(op_reg_en),
    .bit_ct_en_o(bit_ct_en), .bit_ct_rst_o(bit_ct_rst),
    .word_ct_sel_o(word_ct_sel), .word_ct_en_o(word_ct_en),
    .out_reg_ld_en_o(out_reg_ld_en), .out_reg_shift_en_o(out_reg_shift_en),
    .out_reg_data_sel_o(out_reg_data_sel), .tdo_sel_o(tdo_sel), .biu_strobe_o(biu_strobe),
    .crc_clr_o(crc_clr), .crc_en_o(crc_en), .crc_in_sel_o(crc_in_sel),
    .crc_shift_en_o(crc_shift_en), .status_wr_o(status_wr), .top_inhibit_o(top_inhibit_o)
  );

  dbg_cpu_datapath u_datapath (
    .tck_i(tck_i), .tlr_i(tlr_i), .tdi_i(tdi_i), .cmd_i(cmd),
    .addr_sel_i(addr_sel), .addr_ct_en_i(addr_ct_en), .op_reg_en_i(op_reg_en),
    .bit_ct_en_i(bit_ct_en), .bit_ct_rst_i(bit_ct_rst),
    .word_ct_sel_i(word_ct_sel), .word_ct_en_i(word_ct_en),
    .out_reg_ld_en_i(out_reg_ld_en), .out_reg_shift_en_i(out_reg_shift_en),
    .out_reg_data_sel_i(out_reg_data_sel), .tdo_sel_i(tdo_sel), .crc_in_sel_i(crc_in_sel),
    .biu_data_i(rdata), .status_i(cpu_stall_o), .biu_ready_i(biu_ready),
    .crc_data_i(crc_data), .crc_serial_i(crc_serial),
    .addr_o(addr), .wdata_o(wdata), .rd_op_o(rd_op), .tdo_o(module_tdo_o),
    .crc_bit_o(crc_bit), .crc_match_o(),
    .word_count_zero_o(word_count_zero), .word_count_one_o(word_count_one),
    .bit_count_max_o(bit_count_max), .bit_count_32_o(bit_count_32)
  );

  dbg_cpu_biu u_biu (
    .tck_i(tck_i), .tlr_i(tlr_i), .strobe_i(biu_strobe), .rd_wrn_i(rd_op),
    .addr_i(addr), .data_i(wdata), .data_o(rdata), .rdy_o(biu_ready),
    .cpu_addr_o(cpu_addr_o), .cpu_data_i(cpu_data_i), .cpu_data_o(cpu_data_o),
    .cpu_stb_o(cpu_stb_o), .cpu_we_o(cpu_we_o), .cpu_ack_i(cpu_ack_i)
  );

  dbg_cpu_crc32 u_crc (
    .tck_i(tck_i), .tlr_i(tlr_i), .data_i(crc_bit), .enable_i(crc_en),
    .shift_i(crc_shift_en), .clr_i(crc_clr), .crc_o(crc_data), .serial_o(crc_serial)
  );

  dbg_cpu_status_reg u_status (
    .tck_i(tck_i), .tlr_i(tlr_i), .we_i(status_wr), .data_i(cmd.ireg.stall),
    .bp_i(cpu_bp_i), .stall_o(cpu_stall_o)
  );

endmodule

`default_nettype wire

/* tests/tb_dbg_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dbg_cpu;

  logic        tck_i = 1'b0;
  logic        tlr_i = 1'b1;          // Held for the first 3 cycles
  logic        capture_dr_i = 1'b0;
  logic        shift_dr_i = 1'b0;
  logic        update_dr_i = 1'b0;
  logic        tdi_i = 1'b0;
  logic [63:0] data_register_i = '0;
  logic        module_select_i = 1'b1;  // Only module on the chain
  logic        module_tdo_o;
  logic        top_inhibit_o;
  logic [31:0] cpu_addr_o;
  logic [31:0] cpu_data_o;
  logic [31:0] cpu_data_i = '0;
  logic        cpu_stb_o;
  logic        cpu_we_o;
  logic        cpu_ack_i = 1'b0;
  logic        cpu_bp_i = 1'b0;
  logic        cpu_stall_o;

  integer      seed = 82225;
  int          errors = 0;
  int          checks = 0;
  int          wait_cnt = 0;          // Bus latency still to go
  bit          trace_read = 1'b0;
  int          n_ops = 0;
  logic [31:0] t_kind [64];
  logic [31:0] t_addr [64];
  logic [31:0] t_count [64];
  logic [31:0] t_flag [64];           // Corrupt CRC on writes
  logic [31:0] t_data [64][4];
  logic [31:0] mem [logic [31:0]];    // Sparse bus memory
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];
  logic        log_we [$];
  bit          shift_q [$];           // Bits for the next DR shift

  dbg_cpu_module i_dut (.*);

  always #20 tck_i = ~tck_i;

  //////////////////////////////
  // TAP data register, filled from the top

  always @(posedge tck_i) begin
    if (capture_dr_i) data_register_i <= '0;
    else if (shift_dr_i) data_register_i <= {tdi_i, data_register_i[63:1]};
  end

  //////////////////////////////
  // Bus memory with random ack delay

  always @(posedge tck_i) begin
    if (cpu_ack_i) begin
      cpu_ack_i <= 1'b0;  // Strobe drops on the ack edge
    end else if (cpu_stb_o) begin
      if (wait_cnt == 0) begin
        cpu_ack_i <= 1'b1;
        log_addr.push_back(cpu_addr_o);
        log_data.push_back(cpu_data_o);
        log_we.push_back(cpu_we_o);
        if (cpu_we_o) mem[cpu_addr_o] = cpu_data_o;
        else cpu_data_i <= mem.exists(cpu_addr_o) ? mem[cpu_addr_o] : fill_word(cpu_addr_o);
        wait_cnt = $unsigned($random(seed)) % 6;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'hdead0000;  // Unwritten words
  endfunction

  // Reflected CRC-32, one bit, LSB first
  function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic din);
    logic fb;
    fb = din ^ crc[0];
    return (crc >> 1) ^ (fb ? 32'hedb88320 : 32'h0);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("ERROR %0t ns: %s expected %h, got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%0t ns: %s", $time, msg);
  endtask

  task automatic read_trace();
    int          fd;
    string       line;
    logic [31:0] v [8];
    fd = $fopen("tests/dbg_cpu_trace.txt", "r");
    if (fd == 0) begin
      report_failure("Trace file tests/dbg_cpu_trace.txt could not be opened");
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() == 0 || line[0] == "#") continue;  // Column notes
      if ($sscanf(line, "%h %h %h %h %h %h %h %h",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]) < 4) continue;
      t_kind[n_ops]  = v[0];
      t_addr[n_ops]  = v[1];
      t_count[n_ops] = v[2];
      t_flag[n_ops]  = v[3];
      for (int w = 0; w < 4; w++) t_data[n_ops][w] = v[4+w];
      n_ops++;
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // JTAG sequences

  task automatic shift_queue();
    while (shift_q.size() > 0) begin
      @(posedge tck_i);
      shift_dr_i <= 1'b1;
      tdi_i      <= shift_q.pop_front();
    end
    @(posedge tck_i);
    shift_dr_i <= 1'b0;
  endtask

  task automatic load_cmd(input logic [63:0] cmd);
    for (int b = 0; b < 64; b++) shift_q.push_back(cmd[b]);
    shift_queue();
    @(posedge tck_i);
    update_dr_i <= 1'b1;
    @(posedge tck_i);
    update_dr_i <= 1'b0;
  endtask

  task automatic start_burst(input logic [3:0] op, input int i);
    load_cmd({1'b0, op, 4'h0, t_addr[i], t_count[i][15:0], 7'h0});
    @(posedge tck_i);
    capture_dr_i <= 1'b1;  // Controller is waiting for it now
    @(posedge tck_i);
    capture_dr_i <= 1'b0;
  endtask

  task automatic end_burst();
    @(posedge tck_i);
    shift_dr_i  <= 1'b0;
    update_dr_i <= 1'b1;
    @(posedge tck_i);
    update_dr_i <= 1'b0;
  endtask

  task automatic read_status(input logic exp);
    @(posedge tck_i);
    capture_dr_i <= 1'b1;
    @(posedge tck_i);
    capture_dr_i <= 1'b0;
    shift_dr_i   <= 1'b1;
    @(negedge tck_i);
    check_value("module_tdo_o (stall readback)", exp, module_tdo_o);
    @(posedge tck_i);
    shift_dr_i <= 1'b0;
  endtask

  task automatic check_bus(input int first, input int i, input logic we, input int count);
    check_value("number of bus cycles", count, log_addr.size() - first);
    for (int j = 0; j < count && first + j < log_addr.size(); j++) begin
      check_value("cpu_addr_o", t_addr[i] + j, log_addr[first+j]);
      check_value("cpu_we_o", we, log_we[first+j]);
      if (we) check_value("cpu_data_o", t_data[i][j], log_data[first+j]);
    end
  endtask

  task automatic burst_write(input int i);
    logic [31:0] crc;
    int          first;
    first = log_addr.size();
    crc   = 32'hffffffff;
    start_burst(dbg_cpu_pkg::CMD_BWRITE32, i);
    if (t_count[i] != 0) begin
      shift_q.push_back(1'b1);  // Start bit
      for (int w = 0; w < t_count[i]; w++) begin
        for (int b = 0; b < 32; b++) begin
          shift_q.push_back(t_data[i][w][b]);
          crc = crc_step(crc, t_data[i][w][b]);
        end
      end
      if (t_flag[i][0]) crc = crc ^ 32'h1;
      for (int b = 0; b < 32; b++) shift_q.push_back(crc[b]);
      shift_queue();
      @(posedge tck_i);
      @(negedge tck_i);
      check_value("module_tdo_o (CRC match)", {31'b0, ~t_flag[i][0]}, module_tdo_o);
    end
    end_burst();
    check_bus(first, i, 1'b1, t_count[i]);
  endtask

  task automatic burst_read(input int i);
    logic [31:0] crc;
    logic [31:0] word;
    int          first;
    int          cycles;
    first  = log_addr.size();
    crc    = 32'hffffffff;
    cycles = 0;
    start_burst(dbg_cpu_pkg::CMD_BREAD32, i);
    if (t_count[i] != 0) begin
      @(negedge tck_i);
      while (module_tdo_o !== 1'b1 && cycles < 200) begin  // Ready bits
        @(negedge tck_i);
        cycles++;
      end
      if (cycles >= 200) begin
        report_failure($sformatf("Read burst at %h never showed a ready bit", t_addr[i]));
      end else begin
        for (int w = 0; w < t_count[i]; w++) begin
          for (int b = 0; b < 32; b++) begin
            @(negedge tck_i);
            word[b] = module_tdo_o;
            crc = crc_step(crc, t_data[i][w][b]);
          end
          check_value("module_tdo_o (read word)", t_data[i][w], word);
        end
        for (int b = 0; b < 32; b++) begin
          @(negedge tck_i);
          word[b] = module_tdo_o;
        end
        check_value("module_tdo_o (read CRC)", crc, word);
      end
    end
    end_burst();
    check_bus(first, i, 1'b0, t_count[i]);
  endtask

  task automatic early_end(input int i);
    int first;
    first = log_addr.size();
    start_burst(dbg_cpu_pkg::CMD_BWRITE32, i);
    @(negedge tck_i);
    check_value("top_inhibit_o (in burst)", 1, top_inhibit_o);
    shift_q.push_back(1'b1);
    repeat (10) shift_q.push_back(1'b1);  // Far short of one word
    shift_queue();
    end_burst();
    @(negedge tck_i);
    check_value("top_inhibit_o (after update)", 0, top_inhibit_o);
    check_bus(first, i, 1'b1, 0);
  endtask

  //////////////////////////////
  // Main sequence

  initial begin
    read_trace();
    trace_read = 1'b1;
    repeat (3) @(posedge tck_i);
    tlr_i <= 1'b0;
    @(negedge tck_i);
    check_value("top_inhibit_o (reset)", 0, top_inhibit_o);
    check_value("cpu_stb_o (reset)", 0, cpu_stb_o);
    check_value("cpu_stall_o (reset)", 0, cpu_stall_o);
    for (int i = 0; i < n_ops; i++) begin
      case (t_kind[i])
        1: burst_write(i);
        2: burst_read(i);
        3: begin  // Status write
          load_cmd({1'b0, dbg_cpu_pkg::CMD_IREG_WR, dbg_cpu_pkg::INTREG_STATUS,
                    t_data[i][0][0], 57'h0});
          @(negedge tck_i);
          check_value("cpu_stall_o", t_data[i][0][0], cpu_stall_o);
          read_status(t_data[i][0][0]);
        end
        4: begin  // Breakpoint from the core
          @(posedge tck_i);
          cpu_bp_i <= 1'b1;
          @(posedge tck_i);
          cpu_bp_i <= 1'b0;
          @(negedge tck_i);
          check_value("cpu_stall_o (breakpoint)", 1, cpu_stall_o);
          read_status(1'b1);
        end
        5: early_end(i);
        default: report_failure($sformatf("Trace line %0d has an unknown kind", i));
      endcase
    end
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) $display("All checks passed");
    else $display("Checks failed");
    $finish;
  end

  // Watchdog scaled to the trace
  initial begin
    wait (trace_read);
    #((n_ops + 1) * 400 * 40);
    $display("Watchdog ran out of time before the trace finished");
    $display("%0d errors in %0d checks", errors, checks);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/dbg_cpu_trace.txt */
# kind addr count corrupt d0 d1 d2 d3 (all hex)
# kind 1 burst write, 2 burst read, 3 status write of d0, 4 breakpoint, 5 early end
3 00000000 0 0 1 0 0 0
3 00000000 0 0 0 0 0 0
4 00000000 0 0 1 0 0 0
3 00000000 0 0 0 0 0 0
1 00001000 3 0 deadbeef 12345678 a5a5c3c3 0
2 00001000 3 0 deadbeef 12345678 a5a5c3c3 0
1 00002000 1 1 cafef00d 0 0 0
2 00002000 1 0 cafef00d 0 0 0
2 00000100 2 0 dead0100 dead0101 0 0
1 00003000 4 0 01234567 89abcdef 0f1e2d3c 4b5a6978
2 00003002 2 0 0f1e2d3c 4b5a6978 0 0
1 00004000 0 0 0 0 0 0
2 00004000 0 0 0 0 0 0
5 00005000 2 0 0 0 0 0
2 00005000 1 0 dead5000 0 0 0
1 00006000 2 1 55aa55aa ffffffff 0 0
2 00006001 1 0 ffffffff 0 0 0

/* dbg_cpu.f */
design/dbg_cpu_pkg.sv
design/dbg_cpu_crc32.sv
design/dbg_cpu_biu.sv
design/dbg_cpu_status_reg.sv
design/dbg_cpu_ctrl.sv
design/dbg_cpu_datapath.sv
design/dbg_cpu_module.sv
tests/tb_dbg_cpu.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the trace testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dbg_cpu \
		-f dbg_cpu.f -o sim_dbg_cpu
	./obj_dir/sim_dbg_cpu > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
